// ==== common/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// clocks per oversample tick, 4 x 16 gives 64 clocks per bit
`define CLK_PER_TICK 4
`define OVERSAMPLE 16

// word address widths
`define IMEM_AW 8
`define DMEM_AW 6

`endif

// ==== common/mips_pkg.sv ====
package mips_pkg;

	// major opcode field
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// funct field, register-type only
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one instruction word, two decodings
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src_imm;
		logic    dest_rd;
		logic    mem_to_reg;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] pc;
		instr_u     instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] data_a;
		logic [31:0] data_b;
		logic [31:0] imm;
		logic [4:0]  rt;
		logic [4:0]  rd;
	} id_ex_t;

	// register write port, also the trace
	typedef struct packed {
		logic        valid;
		logic [4:0]  reg_addr;
		logic [31:0] data;
	} wb_t;

endpackage

// ==== uart/uart_rx.sv ====
`include "mips_cfg.svh"

module uart_rx (
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       rx_i,
	output logic       byte_valid_o,
	output logic [7:0] byte_data_o
);
	localparam int DIV_W = $clog2(`CLK_PER_TICK + 1);
	localparam int OS_W  = $clog2(`OVERSAMPLE);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CLK_PER_TICK - 1);
	localparam logic [OS_W-1:0]  MID_BIT  = OS_W'(`OVERSAMPLE / 2 - 1);
	localparam logic [OS_W-1:0]  LAST_OS  = OS_W'(`OVERSAMPLE - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_e;

	state_e           state;
	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [1:0]       rx_sync;
	logic             rx;
	logic [OS_W-1:0]  os_cnt;
	logic [2:0]       bit_cnt;

	// oversample tick generator
	assign tick = (div_cnt == DIV_LAST);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// line idles high
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx_i};
		end
	end

	assign rx = rx_sync[1];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state        <= S_IDLE;
			os_cnt       <= '0;
			bit_cnt      <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (!rx) begin
						state  <= S_START;
						os_cnt <= '0;
					end
				end
				S_START: begin
					// recheck at mid start bit, a glitch goes back to idle
					if (tick) begin
						if (os_cnt == MID_BIT) begin
							os_cnt  <= '0;
							bit_cnt <= '0;
							state   <= rx ? S_IDLE : S_DATA;
						end else begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				S_DATA: begin
					if (tick) begin
						if (os_cnt == LAST_OS) begin
							os_cnt      <= '0;
							byte_data_o <= {rx, byte_data_o[7:1]};
							if (bit_cnt == 3'd7) begin
								state <= S_STOP;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end else begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				S_STOP: begin
					if (tick) begin
						if (os_cnt == LAST_OS) begin
							// framing error drops the byte
							byte_valid_o <= rx;
							state        <= S_IDLE;
						end else begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_single_strobe: assert property (@(posedge clock_i) disable iff (reset_i)
		byte_valid_o |=> !byte_valid_o);

endmodule

// ==== loader/program_loader.sv ====
`include "mips_cfg.svh"

module program_loader import mips_pkg::*; (
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                byte_valid_i,
	input  logic [7:0]          byte_data_i,
	output logic                imem_we_o,
	output logic [`IMEM_AW-1:0] imem_waddr_o,
	output instr_u              imem_wdata_o,
	output logic [7:0]          prog_len_o,
	output logic                loaded_o
);
	logic                have_len;
	logic [1:0]          byte_cnt;
	logic [23:0]         shift_q;
	logic [`IMEM_AW-1:0] word_cnt;
	logic                last_wr;
	logic                take;

	// nothing accepted once the program is in
	assign take = byte_valid_i && !loaded_o;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			have_len   <= 1'b0;
			byte_cnt   <= '0;
			word_cnt   <= '0;
			imem_we_o  <= 1'b0;
			last_wr    <= 1'b0;
			prog_len_o <= '0;
			loaded_o   <= 1'b0;
		end else begin
			imem_we_o <= 1'b0;
			if (imem_we_o && last_wr) begin
				loaded_o <= 1'b1;
			end
			if (take && !have_len) begin
				have_len   <= 1'b1;
				prog_len_o <= byte_data_i;
				// empty program
				if (byte_data_i == 8'd0) begin
					loaded_o <= 1'b1;
				end
			end else if (take) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == 2'd3) begin
					imem_we_o <= 1'b1;
					last_wr   <= ((8'(word_cnt) + 8'd1) == prog_len_o);
					word_cnt  <= word_cnt + 1'b1;
				end
			end
		end
	end

	// lsb first, fourth byte completes the word
	always_ff @(posedge clock_i) begin
		if (take && have_len) begin
			shift_q <= {byte_data_i, shift_q[23:8]};
			if (byte_cnt == 2'd3) begin
				imem_waddr_o <= word_cnt;
				imem_wdata_o <= {byte_data_i, shift_q};
			end
		end
	end

	a_waddr_in_range: assert property (@(posedge clock_i) disable iff (reset_i)
		imem_we_o |-> (8'(imem_waddr_o) < prog_len_o));

endmodule

// ==== source/instr_mem.sv ====
`include "mips_cfg.svh"

module instr_mem import mips_pkg::*; (
	input  logic                clock_i,
	input  logic                we_i,
	input  logic [`IMEM_AW-1:0] waddr_i,
	input  instr_u              wdata_i,
	input  logic [`IMEM_AW-1:0] raddr_i,
	output instr_u              rdata_o
);
	instr_u mem [2**`IMEM_AW];

	// loader port
	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// fetch port, one cycle read
	always_ff @(posedge clock_i) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

// ==== core/fetch_stage.sv ====
`include "mips_cfg.svh"

module fetch_stage import mips_pkg::*; (
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                loaded_i,
	input  logic [7:0]          prog_len_i,
	output logic [`IMEM_AW-1:0] imem_raddr_o,
	input  instr_u              imem_rdata_i,
	output if_id_t              if_id_o,
	output logic                halted_o
);
	logic [7:0] pc_q;
	logic [7:0] fetch_pc;
	logic       addr_v;
	logic       rd_v;
	logic [7:0] rd_pc;
	logic       issue;
	logic       all_issued;
	logic [2:0] drain_cnt;

	assign issue      = loaded_i && (pc_q < prog_len_i);
	assign all_issued = loaded_i && (pc_q == prog_len_i);

	assign imem_raddr_o = `IMEM_AW'(fetch_pc);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			pc_q         <= '0;
			fetch_pc     <= '0;
			addr_v       <= 1'b0;
			rd_v         <= 1'b0;
			if_id_o.valid <= 1'b0;
			drain_cnt    <= '0;
			halted_o     <= 1'b0;
		end else begin
			addr_v <= issue;
			if (issue) begin
				fetch_pc <= pc_q;
				pc_q     <= pc_q + 8'd1;
			end
			// valid follows the registered memory read
			rd_v          <= addr_v;
			if_id_o.valid <= rd_v;
			// six cycles to empty the pipe
			if (all_issued && !halted_o) begin
				drain_cnt <= drain_cnt + 1'b1;
				if (drain_cnt == 3'd5) begin
					halted_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_i) begin
		rd_pc         <= fetch_pc;
		if_id_o.pc    <= rd_pc;
		if_id_o.instr <= imem_rdata_i;
	end

	a_pc_bound: assert property (@(posedge clock_i) disable iff (reset_i)
		pc_q <= prog_len_i);

endmodule

// ==== core/decode_stage.sv ====
module decode_stage import mips_pkg::*; (
	input  logic   clock_i,
	input  logic   reset_i,
	input  if_id_t if_id_i,
	input  wb_t    wb_i,
	output id_ex_t id_ex_o
);
	instr_u      instr;
	opcode_e     op;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [15:0] imm_raw;
	logic [31:0] imm;
	ctrl_t       ctrl;
	logic        known;
	logic        issue;
	logic [31:0] data_a;
	logic [31:0] data_b;
	logic [31:0] regs [32];

	assign instr   = if_id_i.instr;
	assign op      = instr.r.opcode;
	assign imm_raw = instr.i.imm;

	// rs and rt sit at the same place in both formats
	assign rs = instr.i.rs;
	assign rt = instr.i.rt;

	always_comb begin
		ctrl  = '0;
		known = 1'b1;
		case (op)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rd   = 1'b1;
				case (instr.r.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_LUI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				case (op)
					OP_ADDI: ctrl.alu_op = ALU_ADD;
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI:  ctrl.alu_op = ALU_OR;
					default: ctrl.alu_op = ALU_PASS_B;
				endcase
			end
			OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_op      = ALU_ADD;
			end
			OP_SW: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = ALU_ADD;
			end
			default: known = 1'b0;
		endcase
	end

	// logical ops take the immediate unsigned
	always_comb begin
		case (op)
			OP_ANDI, OP_ORI: imm = {16'd0, imm_raw};
			OP_LUI:          imm = {imm_raw, 16'd0};
			default:         imm = {{16{imm_raw[15]}}, imm_raw};
		endcase
	end

	// register bank with r0 never written
	always_ff @(posedge clock_i) begin
		if (wb_i.valid && (wb_i.reg_addr != 5'd0)) begin
			regs[wb_i.reg_addr] <= wb_i.data;
		end
	end

	// write-through from writeback
	always_comb begin
		if (rs == 5'd0) begin
			data_a = '0;
		end else if (wb_i.valid && (wb_i.reg_addr == rs)) begin
			data_a = wb_i.data;
		end else begin
			data_a = regs[rs];
		end
		if (rt == 5'd0) begin
			data_b = '0;
		end else if (wb_i.valid && (wb_i.reg_addr == rt)) begin
			data_b = wb_i.data;
		end else begin
			data_b = regs[rt];
		end
	end

	// unknown opcode leaves as a bubble
	assign issue = if_id_i.valid && known;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			id_ex_o.valid <= 1'b0;
			id_ex_o.ctrl  <= '0;
		end else begin
			id_ex_o.valid <= issue;
			id_ex_o.ctrl  <= issue ? ctrl : '0;
		end
	end

	always_ff @(posedge clock_i) begin
		id_ex_o.data_a <= data_a;
		id_ex_o.data_b <= data_b;
		id_ex_o.imm    <= imm;
		id_ex_o.rt     <= rt;
		id_ex_o.rd     <= instr.r.rd;
	end

endmodule

// ==== core/exec_mem_stage.sv ====
`include "mips_cfg.svh"

module exec_mem_stage import mips_pkg::*; (
	input  logic   clock_i,
	input  logic   reset_i,
	input  id_ex_t id_ex_i,
	output wb_t    wb_o
);
	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] alu_res;
		logic [31:0] store_data;
		logic [4:0]  dest;
	} ex_mem_t;

	ex_mem_t             ex_mem;
	logic [31:0]         op_b;
	logic [31:0]         alu_res;
	logic [4:0]          dest;
	logic [`DMEM_AW-1:0] dmem_addr;
	logic [31:0]         mem_rdata;
	logic [31:0]         dmem [2**`DMEM_AW];

	always_comb begin
		op_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : id_ex_i.data_b;
		case (id_ex_i.ctrl.alu_op)
			ALU_ADD: alu_res = id_ex_i.data_a + op_b;
			ALU_SUB: alu_res = id_ex_i.data_a - op_b;
			ALU_AND: alu_res = id_ex_i.data_a & op_b;
			ALU_OR:  alu_res = id_ex_i.data_a | op_b;
			ALU_XOR: alu_res = id_ex_i.data_a ^ op_b;
			ALU_SLT: alu_res = {31'd0, $signed(id_ex_i.data_a) < $signed(op_b)};
			default: alu_res = op_b;
		endcase
	end

	assign dest = id_ex_i.ctrl.dest_rd ? id_ex_i.rd : id_ex_i.rt;

	// EX/MEM
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
		end else begin
			ex_mem.valid <= id_ex_i.valid;
			ex_mem.ctrl  <= id_ex_i.ctrl;
		end
	end

	always_ff @(posedge clock_i) begin
		ex_mem.alu_res    <= alu_res;
		ex_mem.store_data <= id_ex_i.data_b;
		ex_mem.dest       <= dest;
	end

	// word addressed, upper address bits ignored
	assign dmem_addr = ex_mem.alu_res[`DMEM_AW-1:0];
	assign mem_rdata = dmem[dmem_addr];

	always_ff @(posedge clock_i) begin
		if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
			dmem[dmem_addr] <= ex_mem.store_data;
		end
	end

	// MEM/WB
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			wb_o.valid <= 1'b0;
		end else begin
			wb_o.valid <= ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dest != 5'd0);
		end
	end

	always_ff @(posedge clock_i) begin
		wb_o.reg_addr <= ex_mem.dest;
		wb_o.data     <= ex_mem.ctrl.mem_to_reg ? mem_rdata : ex_mem.alu_res;
	end

	a_no_rd_wr: assert property (@(posedge clock_i) disable iff (reset_i)
		ex_mem.valid |-> !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write));

endmodule

// ==== source/mips_top.sv ====
`include "mips_cfg.svh"

module mips_top import mips_pkg::*; (
	input  logic clock_i,
	input  logic reset_i,
	input  logic rx_i,
	output logic loaded_o,
	output logic halted_o,
	output wb_t  wb_o
);
	logic                byte_valid;
	logic [7:0]          byte_data;
	logic                imem_we;
	logic [`IMEM_AW-1:0] imem_waddr;
	instr_u              imem_wdata;
	logic [7:0]          prog_len;
	logic [`IMEM_AW-1:0] imem_raddr;
	instr_u              imem_rdata;
	if_id_t              if_id;
	id_ex_t              id_ex;

	// program download
	uart_rx uart_rx_inst (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.rx_i         (rx_i),
		.byte_valid_o (byte_valid),
		.byte_data_o  (byte_data)
	);

	program_loader program_loader_inst (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.byte_valid_i (byte_valid),
		.byte_data_i  (byte_data),
		.imem_we_o    (imem_we),
		.imem_waddr_o (imem_waddr),
		.imem_wdata_o (imem_wdata),
		.prog_len_o   (prog_len),
		.loaded_o     (loaded_o)
	);

	instr_mem instr_mem_inst (
		.clock_i (clock_i),
		.we_i    (imem_we),
		.waddr_i (imem_waddr),
		.wdata_i (imem_wdata),
		.raddr_i (imem_raddr),
		.rdata_o (imem_rdata)
	);

	// pipeline
	fetch_stage fetch_stage_inst (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.loaded_i     (loaded_o),
		.prog_len_i   (prog_len),
		.imem_raddr_o (imem_raddr),
		.imem_rdata_i (imem_rdata),
		.if_id_o      (if_id),
		.halted_o     (halted_o)
	);

	decode_stage decode_stage_inst (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.if_id_i (if_id),
		.wb_i    (wb_o),
		.id_ex_o (id_ex)
	);

	exec_mem_stage exec_mem_stage_inst (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.id_ex_i (id_ex),
		.wb_o    (wb_o)
	);

endmodule

// ==== sim/tb_mips_top.sv ====
`include "mips_cfg.svh"

module tb_mips_top import mips_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BIT_CLKS     = `CLK_PER_TICK * `OVERSAMPLE;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 200;
	localparam int TAIL_CYCLES  = 20;
	localparam int NOPS_AFTER   = 3;

	typedef instr_u word_q_t[$];
	typedef wb_t wb_q_t[$];

	logic        clock;
	logic        reset;
	logic        rx;
	logic        loaded;
	logic        halted;
	wb_t         wb;

	word_q_t     prog_q;
	word_q_t     alu_prog;
	word_q_t     mem_prog;
	word_q_t     rand_prog;
	wb_q_t       exp_q;
	wb_t         exp_rec;
	logic        trace_on;
	logic [31:0] rand_state = 32'd28;
	int unsigned budget_cycles;
	int          first_trace_len;

	mips_top mips_top_inst (
		.clock_i  (clock),
		.reset_i  (reset),
		.rx_i     (rx),
		.loaded_o (loaded),
		.halted_o (halted),
		.wb_o     (wb)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	// instruction encoders in assembly operand order
	function automatic instr_u enc_r(funct_e fn, logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
		instr_u w;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = '0;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic instr_u enc_i(opcode_e op, logic [4:0] rt, logic [4:0] rs,
			logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	// instruction then nops so no operand hazard is possible
	function automatic void push_spaced(instr_u w);
		int k;
		prog_q.push_back(w);
		for (k = 0; k < NOPS_AFTER; k++) begin
			prog_q.push_back(enc_r(FN_OR, 5'd0, 5'd0, 5'd0));
		end
	endfunction

	function automatic void build_alu_program();
		prog_q.delete();
		push_spaced(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h1234));
		push_spaced(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hfffb));
		push_spaced(enc_i(OP_LUI, 5'd3, 5'd0, 16'ha5a5));
		push_spaced(enc_i(OP_ORI, 5'd4, 5'd3, 16'h0f0f));
		push_spaced(enc_i(OP_ANDI, 5'd5, 5'd4, 16'hff00));
		push_spaced(enc_r(FN_ADDU, 5'd6, 5'd1, 5'd2));
		push_spaced(enc_r(FN_SUBU, 5'd7, 5'd1, 5'd2));
		push_spaced(enc_r(FN_AND, 5'd8, 5'd4, 5'd2));
		push_spaced(enc_r(FN_OR, 5'd9, 5'd1, 5'd3));
		push_spaced(enc_r(FN_XOR, 5'd10, 5'd4, 5'd1));
		push_spaced(enc_r(FN_SLT, 5'd11, 5'd2, 5'd1));
		push_spaced(enc_r(FN_SLT, 5'd12, 5'd1, 5'd2));
		// r0 target gives no trace
		push_spaced(enc_i(OP_ADDI, 5'd0, 5'd1, 16'd7));
		push_spaced(enc_r(FN_ADDU, 5'd13, 5'd0, 5'd4));
	endfunction

	// every load reads a word that this program stored
	function automatic void build_mem_program();
		prog_q.delete();
		push_spaced(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h55aa));
		push_spaced(enc_i(OP_LUI, 5'd2, 5'd0, 16'hdead));
		push_spaced(enc_i(OP_ORI, 5'd2, 5'd2, 16'hbeef));
		push_spaced(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd8));
		push_spaced(enc_i(OP_SW, 5'd1, 5'd3, 16'd0));
		push_spaced(enc_i(OP_SW, 5'd2, 5'd3, 16'd1));
		push_spaced(enc_i(OP_LW, 5'd4, 5'd3, 16'd0));
		push_spaced(enc_i(OP_LW, 5'd5, 5'd3, 16'd1));
		push_spaced(enc_i(OP_SW, 5'd4, 5'd0, 16'd12));
		push_spaced(enc_i(OP_SW, 5'd2, 5'd0, 16'd8));
		push_spaced(enc_i(OP_LW, 5'd6, 5'd0, 16'd8));
		push_spaced(enc_i(OP_LW, 5'd7, 5'd0, 16'd12));
		// negative offset, then an address past the memory size
		push_spaced(enc_i(OP_SW, 5'd1, 5'd3, 16'hffff));
		push_spaced(enc_i(OP_LW, 5'd8, 5'd0, 16'd7));
		push_spaced(enc_i(OP_LW, 5'd9, 5'd0, 16'd73));
	endfunction

	function automatic void build_random_program();
		logic [31:0] r;
		logic [31:0] v;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		int          k;
		prog_q.delete();
		// r1..r7 get known values first
		for (k = 1; k < 8; k++) begin
			v = next_rand();
			push_spaced(enc_i(OP_ORI, 5'(k), 5'd0, v[15:0]));
		end
		for (k = 0; k < 24; k++) begin
			r  = next_rand();
			v  = next_rand();
			rd = {2'b00, r[10:8]};
			rs = {2'b00, r[14:12]};
			rt = {2'b00, r[18:16]};
			case (r[31:24] % 10)
				0: push_spaced(enc_r(FN_ADDU, rd, rs, rt));
				1: push_spaced(enc_r(FN_SUBU, rd, rs, rt));
				2: push_spaced(enc_r(FN_AND, rd, rs, rt));
				3: push_spaced(enc_r(FN_OR, rd, rs, rt));
				4: push_spaced(enc_r(FN_XOR, rd, rs, rt));
				5: push_spaced(enc_r(FN_SLT, rd, rs, rt));
				6: push_spaced(enc_i(OP_ADDI, rd, rs, v[15:0]));
				7: push_spaced(enc_i(OP_ANDI, rd, rs, v[15:0]));
				8: push_spaced(enc_i(OP_ORI, rd, rs, v[15:0]));
				default: push_spaced(enc_i(OP_LUI, rd, rs, v[15:0]));
			endcase
		end
	endfunction

	// architectural model executing one instruction at a time in program order
	function automatic wb_q_t model_program(input word_q_t prog);
		logic [31:0] regs [32];
		logic [31:0] dmem [2**`DMEM_AW];
		instr_u      w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] ea;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        writes;
		wb_t         rec;
		wb_q_t       trace;
		int          k;
		for (k = 0; k < 32; k++) begin
			regs[k] = '0;
		end
		for (k = 0; k < 2**`DMEM_AW; k++) begin
			dmem[k] = '0;
		end
		for (k = 0; k < prog.size(); k++) begin
			w      = prog[k];
			a      = regs[w.i.rs];
			b      = regs[w.i.rt];
			sext   = {{16{w.i.imm[15]}}, w.i.imm};
			ea     = a + sext;
			dest   = w.i.rt;
			writes = 1'b1;
			res    = '0;
			case (w.i.opcode)
				OP_RTYPE: begin
					dest = w.r.rd;
					case (w.r.funct)
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				OP_ADDI: res = ea;
				OP_ANDI: res = a & {16'd0, w.i.imm};
				OP_ORI:  res = a | {16'd0, w.i.imm};
				OP_LUI:  res = {w.i.imm, 16'd0};
				OP_LW:   res = dmem[ea[`DMEM_AW-1:0]];
				OP_SW: begin
					dmem[ea[`DMEM_AW-1:0]] = b;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && (dest != 5'd0)) begin
				regs[dest]   = res;
				rec.valid    = 1'b1;
				rec.reg_addr = dest;
				rec.data     = res;
				trace.push_back(rec);
			end
		end
		return trace;
	endfunction

	function automatic int unsigned frame_cycles(int words);
		return (1 + 4 * words) * 10 * BIT_CLKS + 2 * words + 100;
	endfunction

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_writeback(input wb_t got, input wb_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: wb_o is %b/r%0d/%h, expected %b/r%0d/%h", $time,
				got.valid, got.reg_addr, got.data, exp.valid, exp.reg_addr, exp.data);
			stop_with_failure();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_quiet_outputs();
		check_level("loaded_o", loaded, 1'b0);
		check_level("halted_o", halted, 1'b0);
		check_level("wb_o.valid", wb.valid, 1'b0);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			check_quiet_outputs();
		end
	endtask

	// reset is sampled from the edge after it is driven
	task automatic apply_reset();
		int i;
		@(posedge clock);
		reset <= 1'b1;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clock);
			if (i > 0) begin
				check_quiet_outputs();
			end
			@(posedge clock);
		end
		reset <= 1'b0;
	endtask

	task automatic drive_bit(input logic value);
		@(posedge clock);
		rx <= value;
		repeat (BIT_CLKS - 1) @(posedge clock);
	endtask

	task automatic send_byte(input logic [7:0] data, input logic last);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		// program must not start before the final stop bit
		if (last) begin
			@(negedge clock);
			check_level("loaded_o", loaded, 1'b0);
		end
		drive_bit(1'b1);
	endtask

	task automatic send_frame(input word_q_t prog);
		logic [31:0] w;
		int          k;
		int          b;
		send_byte(8'(prog.size()), 1'b0);
		for (k = 0; k < prog.size(); k++) begin
			w = prog[k];
			for (b = 0; b < 4; b++) begin
				send_byte(w[8*b +: 8], (k == prog.size() - 1) && (b == 3));
			end
		end
		@(negedge clock);
		check_level("loaded_o", loaded, 1'b1);
	endtask

	task automatic run_program(input word_q_t prog);
		exp_q = model_program(prog);
		trace_on = 1'b1;
		send_frame(prog);
		while (!halted) @(negedge clock);
		repeat (TAIL_CYCLES) @(negedge clock);
		if (exp_q.size() != 0) begin
			$display("Error at time %0t: program halted with %0d writebacks still missing",
				$time, exp_q.size());
			stop_with_failure();
		end
		check_level("halted_o", halted, 1'b1);
	endtask

	// trace compare on the falling edge
	always @(negedge clock) begin
		if (!reset && wb.valid) begin
			if (!loaded) begin
				$display("Error at time %0t: a writeback appeared before the program loaded", $time);
				stop_with_failure();
			end
			if (halted) begin
				$display("Error at time %0t: a writeback appeared after halted_o rose", $time);
				stop_with_failure();
			end
			if (trace_on) begin
				if (exp_q.size() == 0) begin
					$display("Error at time %0t: writeback to r%0d with none expected",
						$time, wb.reg_addr);
					stop_with_failure();
				end
				exp_rec = exp_q.pop_front();
				check_writeback(wb, exp_rec);
			end
		end
	end

	initial begin
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge clock);
		$display("Error: the run hung and did not finish within %0d cycles", budget_cycles);
		stop_with_failure();
	end

	initial begin
		clock    = 1'b0;
		reset    = 1'b1;
		rx       = 1'b1;
		trace_on = 1'b0;

		build_alu_program();
		alu_prog = prog_q;
		build_mem_program();
		mem_prog = prog_q;
		build_random_program();
		rand_prog = prog_q;

		budget_cycles = 2 * frame_cycles(alu_prog.size()) + 2 * frame_cycles(mem_prog.size())
			+ frame_cycles(rand_prog.size()) + 6 * (RESET_CYCLES + 2)
			+ 2 * IDLE_CYCLES + 4 * TAIL_CYCLES;

		// reset with the line idle
		apply_reset();
		check_idle(IDLE_CYCLES);

		run_program(alu_prog);

		apply_reset();
		run_program(mem_prog);

		apply_reset();
		run_program(rand_prog);

		// interrupt a run after a few writebacks
		apply_reset();
		exp_q = model_program(alu_prog);
		first_trace_len = exp_q.size();
		trace_on = 1'b1;
		send_frame(alu_prog);
		while (exp_q.size() > first_trace_len - 4) @(posedge clock);
		trace_on = 1'b0;
		apply_reset();
		check_idle(IDLE_CYCLES);
		run_program(mem_prog);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
common/mips_pkg.sv
uart/uart_rx.sv
loader/program_loader.sv
source/instr_mem.sv
core/fetch_stage.sv
core/decode_stage.sv
core/exec_mem_stage.sv
source/mips_top.sv
sim/tb_mips_top.sv
